/* sources.f */
common/axi_rd_pkg.sv
common/splitter_cfg_pkg.sv
burst_splitter/ar_splitter.sv
burst_splitter/beat_len_queue.sv
burst_splitter/r_last_gen.sv
src/axi_rd_burst_splitter.sv
test/burst_splitter_asserts.sv
test/tb_burst_splitter.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the burst splitter testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_burst_splitter -f sources.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

/* test/tb_burst_splitter.sv */
// Testbench for the AXI4 read burst splitter with a downstream memory model and scoreboard
`timescale 1ns/10ps
`default_nettype none

module tb_burst_splitter
  import axi_rd_pkg::*;
  import splitter_cfg_pkg::*;
;

  localparam logic [31:0] SEED      = 32'h20825964;
  localparam data_t       DATA_MASK = 32'h5A5A_0000;

  logic   clk_i = 1'b0;
  logic   rst_n_i;
  addr_t  s_ar_addr_i;
  id_t    s_ar_id_i;
  len_t   s_ar_len_i;
  size_t  s_ar_size_i;
  burst_e s_ar_burst_i;
  logic   s_ar_valid_i;
  logic   s_ar_ready_o;
  addr_t  m_ar_addr_o;
  id_t    m_ar_id_o;
  len_t   m_ar_len_o;
  size_t  m_ar_size_o;
  burst_e m_ar_burst_o;
  logic   m_ar_valid_o;
  logic   m_ar_ready_i;
  data_t  m_r_data_i;
  id_t    m_r_id_i;
  resp_t  m_r_resp_i;
  logic   m_r_valid_i;
  logic   m_r_ready_o;
  data_t  s_r_data_o;
  id_t    s_r_id_o;
  resp_t  s_r_resp_o;
  logic   s_r_last_o;
  logic   s_r_valid_o;
  logic   s_r_ready_i;

  // Burst list, built once before reset is released
  string  q_name[$];
  addr_t  q_addr[$];
  id_t    q_id[$];
  len_t   q_len[$];
  size_t  q_size[$];
  burst_e q_burst[$];
  bit     q_stress[$];

  // Scoreboard of downstream ARs and upstream R beats
  string  exp_ar_test[$];
  addr_t  exp_ar_addr[$];
  id_t    exp_ar_id[$];
  size_t  exp_ar_size[$];
  burst_e exp_ar_burst[$];
  string  exp_r_test[$];
  data_t  exp_r_data[$];
  id_t    exp_r_id[$];
  logic   exp_r_last[$];

  // Memory model: single-beat reads waiting for an R beat
  addr_t  pend_addr[$];
  id_t    pend_id[$];
  bit     r_done = 1'b0;

  bit          stress = 1'b0;
  int unsigned errors = 0;
  int unsigned ar_seen = 0;
  int unsigned r_seen = 0;
  int unsigned total_beats = 0;
  int unsigned limit_cycles = 0;

  axi_rd_burst_splitter dut0 (.*);

  bind axi_rd_burst_splitter burst_splitter_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_len_o   (m_ar_len_o),
    .s_r_valid_o  (s_r_valid_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o)
  );

  always #4 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Reference model and checks
  // ----------------------------------------------------------------------
  function automatic addr_t expected_addr(addr_t start, size_t size, burst_e burst,
                                          int unsigned k);
    if (burst == BURST_FIXED) begin
      return start;
    end
    return start + (addr_t'(k) << size);
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("Fail %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic add_burst(input string name, input burst_e burst, input len_t len,
                           input size_t size, input bit stress_on);
    addr_t a;
    a = addr_t'($urandom);
    // Start address aligned to the beat size
    a = (a >> size) << size;
    q_name.push_back(name);
    q_addr.push_back(a);
    q_id.push_back(id_t'($urandom));
    q_len.push_back(len);
    q_size.push_back(size);
    q_burst.push_back(burst);
    q_stress.push_back(stress_on);
    total_beats += int'(len) + 1;
  endtask

  // Called one step after a rising edge, returns at the same phase
  task automatic send_burst(input int i);
    bit          accepted;
    int unsigned k;
    addr_t       a;
    for (k = 0; k <= int'(q_len[i]); k++) begin
      a = expected_addr(q_addr[i], q_size[i], q_burst[i], k);
      exp_ar_test.push_back(q_name[i]);
      exp_ar_addr.push_back(a);
      exp_ar_id.push_back(q_id[i]);
      exp_ar_size.push_back(q_size[i]);
      exp_ar_burst.push_back(q_burst[i]);
      exp_r_test.push_back(q_name[i]);
      exp_r_data.push_back(a ^ DATA_MASK);
      exp_r_id.push_back(q_id[i]);
      exp_r_last.push_back(k == int'(q_len[i]));
    end
    s_ar_addr_i  = q_addr[i];
    s_ar_id_i    = q_id[i];
    s_ar_len_i   = q_len[i];
    s_ar_size_i  = q_size[i];
    s_ar_burst_i = q_burst[i];
    s_ar_valid_i = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = s_ar_ready_o;
      @(posedge clk_i);
      #1;
    end
    s_ar_valid_i = 1'b0;
  endtask

  // Handshakes are sampled mid-cycle, where inputs and outputs are settled
  always @(negedge clk_i) begin : compare
    string tname;
    if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      ar_seen++;
      if (exp_ar_addr.size() == 0) begin
        errors++;
        $display("Downstream AR to %h was issued with no burst outstanding", m_ar_addr_o);
      end else begin
        tname = exp_ar_test.pop_front();
        check_val({tname, " ar_addr"}, exp_ar_addr.pop_front(), m_ar_addr_o);
        check_val({tname, " ar_id"}, 32'(exp_ar_id.pop_front()), 32'(m_ar_id_o));
        check_val({tname, " ar_len"}, 32'd0, 32'(m_ar_len_o));
        check_val({tname, " ar_size"}, 32'(exp_ar_size.pop_front()), 32'(m_ar_size_o));
        check_val({tname, " ar_burst"}, 32'(exp_ar_burst.pop_front()), 32'(m_ar_burst_o));
      end
    end
    if (rst_n_i && s_r_valid_o && s_r_ready_i) begin
      r_seen++;
      if (exp_r_data.size() == 0) begin
        errors++;
        $display("Upstream R beat %h arrived with no beat outstanding", s_r_data_o);
      end else begin
        tname = exp_r_test.pop_front();
        check_val({tname, " r_data"}, exp_r_data.pop_front(), s_r_data_o);
        check_val({tname, " r_id"}, 32'(exp_r_id.pop_front()), 32'(s_r_id_o));
        check_val({tname, " r_last"}, 32'(exp_r_last.pop_front()), 32'(s_r_last_o));
        check_val({tname, " r_resp"}, 32'(RESP_OKAY), 32'(s_r_resp_o));
      end
    end
  end

  // ----------------------------------------------------------------------
  // Downstream memory model and ready levels
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_n_i && m_r_valid_i && m_r_ready_o) begin
      r_done = 1'b1;
      void'(pend_addr.pop_front());
      void'(pend_id.pop_front());
    end
    if (rst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      pend_addr.push_back(m_ar_addr_o);
      pend_id.push_back(m_ar_id_o);
    end
  end

  always @(posedge clk_i) begin
    #1;
    // A presented beat stays until it is taken
    if (!m_r_valid_i || r_done) begin
      if (pend_addr.size() > 0 && (!stress || ($urandom % 3) != 0)) begin
        m_r_data_i  = pend_addr[0] ^ DATA_MASK;
        m_r_id_i    = pend_id[0];
        m_r_resp_i  = RESP_OKAY;
        m_r_valid_i = 1'b1;
      end else begin
        m_r_valid_i = 1'b0;
      end
    end
    r_done = 1'b0;
  end

  always @(posedge clk_i) begin
    #1;
    if (stress) begin
      m_ar_ready_i = ($urandom % 4) != 0;
      s_r_ready_i  = ($urandom % 4) != 0;
    end else begin
      m_ar_ready_i = 1'b1;
      s_r_ready_i  = 1'b1;
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    int i;
    void'($urandom(SEED));
    rst_n_i      = 1'b0;
    s_ar_addr_i  = '0;
    s_ar_id_i    = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = BURST_INCR;
    s_ar_valid_i = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_data_i   = '0;
    m_r_id_i     = '0;
    m_r_resp_i   = RESP_OKAY;
    m_r_valid_i  = 1'b0;
    s_r_ready_i  = 1'b0;

    for (i = 0; i < 4; i++) begin
      add_burst("single_incr", BURST_INCR, '0, 3'd2, 1'b0);
    end
    for (i = 0; i < 8; i++) begin
      add_burst("incr_burst", BURST_INCR, len_t'($urandom % 16), size_t'($urandom % 3), 1'b0);
    end
    for (i = 0; i < 4; i++) begin
      add_burst("fixed_burst", BURST_FIXED, len_t'(1 + $urandom % 8),
                size_t'($urandom % 3), 1'b0);
    end
    for (i = 0; i < 24; i++) begin
      add_burst("stress_mixed", (($urandom % 2) != 0) ? BURST_INCR : BURST_FIXED,
                len_t'($urandom % 12), size_t'($urandom % 3), 1'b1);
    end
    limit_cycles = total_beats * 40;

    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (i = 0; i < q_addr.size(); i++) begin
      if (q_stress[i] && !stress) begin
        @(negedge clk_i);
        stress = 1'b1;
        @(posedge clk_i);
        #1;
      end
      send_burst(i);
      if (stress) begin
        repeat ($urandom % 3) begin
          @(posedge clk_i);
          #1;
        end
      end
    end

    while (exp_ar_addr.size() != 0 || exp_r_data.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    errors += dut0.u_asserts.fail_cnt;
    $display("Errors: %0d, downstream ARs: %0d, upstream R beats: %0d, expected beats: %0d",
             errors, ar_seen, r_seen, total_beats);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/burst_splitter_asserts.sv */
// Protocol assertions bound to the read burst splitter top level
`timescale 1ns/10ps
`default_nettype none

module burst_splitter_asserts
  import axi_rd_pkg::*;
(
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic m_ar_valid_o,
  input wire len_t m_ar_len_o,
  input wire logic s_r_valid_o,
  input wire logic m_r_valid_i,
  input wire logic m_r_ready_o
);

  int unsigned fail_cnt = 0;

  // Every downstream request is a single beat
  ar_single_beat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_ar_valid_o |-> (m_ar_len_o == '0))
    else begin
      fail_cnt++;
      $error("Downstream AR is valid with a nonzero length");
    end

  // Upstream R only carries a beat that downstream presents
  r_valid_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_r_valid_o |-> m_r_valid_i)
    else begin
      fail_cnt++;
      $error("Upstream R is valid without a downstream R beat");
    end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> (!m_ar_valid_o && !s_r_valid_o && !m_r_ready_o))
    else begin
      fail_cnt++;
      $error("A valid or ready output is high during reset");
    end

endmodule

`default_nettype wire

/* src/axi_rd_burst_splitter.sv */
// AXI4 read burst splitter top level: single-beat ARs down, rebuilt R last up
`timescale 1ns/10ps
`default_nettype none

module axi_rd_burst_splitter
  import axi_rd_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_n_i,
  // Upstream AR
  input  wire addr_t  s_ar_addr_i,
  input  wire id_t    s_ar_id_i,
  input  wire len_t   s_ar_len_i,
  input  wire size_t  s_ar_size_i,
  input  wire burst_e s_ar_burst_i,
  input  wire logic   s_ar_valid_i,
  output logic        s_ar_ready_o,
  // Downstream AR
  output addr_t       m_ar_addr_o,
  output id_t         m_ar_id_o,
  output len_t        m_ar_len_o,
  output size_t       m_ar_size_o,
  output burst_e      m_ar_burst_o,
  output logic        m_ar_valid_o,
  input  wire logic   m_ar_ready_i,
  // Downstream R, without last
  input  wire data_t  m_r_data_i,
  input  wire id_t    m_r_id_i,
  input  wire resp_t  m_r_resp_i,
  input  wire logic   m_r_valid_i,
  output logic        m_r_ready_o,
  // Upstream R
  output data_t       s_r_data_o,
  output id_t         s_r_id_o,
  output resp_t       s_r_resp_o,
  output logic        s_r_last_o,
  output logic        s_r_valid_o,
  input  wire logic   s_r_ready_i
);

  logic q_full;
  logic q_push;
  len_t q_push_len;
  logic q_pop;
  len_t head_len;
  logic head_valid;

  ar_splitter u_ar_splitter (
    .clk_i,
    .rst_n_i,
    .s_ar_addr_i,
    .s_ar_id_i,
    .s_ar_len_i,
    .s_ar_size_i,
    .s_ar_burst_i,
    .s_ar_valid_i,
    .s_ar_ready_o,
    .m_ar_addr_o,
    .m_ar_id_o,
    .m_ar_len_o,
    .m_ar_size_o,
    .m_ar_burst_o,
    .m_ar_valid_o,
    .m_ar_ready_i,
    .q_full_i     (q_full),
    .q_push_o     (q_push),
    .q_push_len_o (q_push_len)
  );

  beat_len_queue u_beat_len_queue (
    .clk_i,
    .rst_n_i,
    .push_i       (q_push),
    .push_len_i   (q_push_len),
    .full_o       (q_full),
    .pop_i        (q_pop),
    .head_len_o   (head_len),
    .head_valid_o (head_valid)
  );

  r_last_gen u_r_last_gen (
    .clk_i,
    .rst_n_i,
    .m_r_data_i,
    .m_r_id_i,
    .m_r_resp_i,
    .m_r_valid_i,
    .m_r_ready_o,
    .s_r_data_o,
    .s_r_id_o,
    .s_r_resp_o,
    .s_r_last_o,
    .s_r_valid_o,
    .s_r_ready_i,
    .head_len_i   (head_len),
    .head_valid_i (head_valid),
    .q_pop_o      (q_pop)
  );

endmodule

`default_nettype wire

/* burst_splitter/r_last_gen.sv */
// R last generator: forwards R beats upstream and rebuilds the last flag
`timescale 1ns/10ps
`default_nettype none

module r_last_gen
  import axi_rd_pkg::*;
  import splitter_cfg_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  // Downstream R
  input  wire data_t m_r_data_i,
  input  wire id_t   m_r_id_i,
  input  wire resp_t m_r_resp_i,
  input  wire logic  m_r_valid_i,
  output logic       m_r_ready_o,
  // Upstream R
  output data_t      s_r_data_o,
  output id_t        s_r_id_o,
  output resp_t      s_r_resp_o,
  output logic       s_r_last_o,
  output logic       s_r_valid_o,
  input  wire logic  s_r_ready_i,
  // Length queue
  input  wire len_t  head_len_i,
  input  wire logic  head_valid_i,
  output logic       q_pop_o
);

  rlast_state_e state_q;
  beat_cnt_t    cnt_q;
  logic         last_q;
  logic         fire;

  // Payload goes straight through
  assign s_r_data_o = m_r_data_i;
  assign s_r_id_o   = m_r_id_i;
  assign s_r_resp_o = m_r_resp_i;

  always_comb begin
    if (state_q == R_HOLD) begin
      s_r_valid_o = m_r_valid_i;
      s_r_last_o  = last_q;
    end else begin
      // No length at the head means the beat cannot be classified yet
      s_r_valid_o = m_r_valid_i && head_valid_i;
      s_r_last_o  = (cnt_q == beat_cnt_t'(head_len_i));
    end
  end

  // Downstream is released only together with the upstream handshake
  assign m_r_ready_o = s_r_valid_o && s_r_ready_i;
  assign fire        = m_r_ready_o;
  assign q_pop_o     = fire && s_r_last_o;

  // ----------------------------------------------------------------------
  // Beat counter and hold state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= R_PASS;
      cnt_q   <= '0;
      last_q  <= 1'b0;
    end else begin
      if (fire) begin
        cnt_q   <= s_r_last_o ? '0 : cnt_q + 1'b1;
        state_q <= R_PASS;
      end else if (s_r_valid_o) begin
        // Upstream stalls, freeze the flag with the beat
        state_q <= R_HOLD;
        last_q  <= s_r_last_o;
      end
    end
  end

endmodule

`default_nettype wire

/* burst_splitter/beat_len_queue.sv */
// Burst length queue: in-order FIFO of lengths for bursts awaiting R data
`timescale 1ns/10ps
`default_nettype none

module beat_len_queue
  import axi_rd_pkg::*;
  import splitter_cfg_pkg::*;
#(
  parameter int DEPTH = MAX_RD_TXNS
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic push_i,
  input  wire len_t push_len_i,
  output logic      full_o,
  input  wire logic pop_i,
  output len_t      head_len_o,
  output logic      head_valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  len_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Pointer step with wrap at DEPTH, so any depth works
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o       = (count_q == CNT_W'(DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_len_o   = mem[rd_ptr_q];

  // Guard against overflow and underflow
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && head_valid_o;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_len_i;
    end
  end

endmodule

`default_nettype wire

/* burst_splitter/ar_splitter.sv */
// AR splitter: turns each upstream read burst into a run of single-beat ARs
`timescale 1ns/10ps
`default_nettype none

module ar_splitter
  import axi_rd_pkg::*;
  import splitter_cfg_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_n_i,
  // Upstream AR
  input  wire addr_t  s_ar_addr_i,
  input  wire id_t    s_ar_id_i,
  input  wire len_t   s_ar_len_i,
  input  wire size_t  s_ar_size_i,
  input  wire burst_e s_ar_burst_i,
  input  wire logic   s_ar_valid_i,
  output logic        s_ar_ready_o,
  // Downstream AR
  output addr_t       m_ar_addr_o,
  output id_t         m_ar_id_o,
  output len_t        m_ar_len_o,
  output size_t       m_ar_size_o,
  output burst_e      m_ar_burst_o,
  output logic        m_ar_valid_o,
  input  wire logic   m_ar_ready_i,
  // Length queue
  input  wire logic   q_full_i,
  output logic        q_push_o,
  output len_t        q_push_len_o
);

  split_state_e state_q;
  logic         rdy_en_q;
  logic         can_take;

  // Stored burst, rem_q counts the beats still to send minus one
  addr_t  addr_q;
  id_t    id_q;
  size_t  size_q;
  burst_e burst_q;
  len_t   rem_q;

  function automatic addr_t next_addr(addr_t addr, size_t size, burst_e burst);
    next_addr = (burst == BURST_INCR) ? addr + (addr_t'(1) << size) : addr;
  endfunction

  // Idle with room for one more length in the queue
  assign can_take = rdy_en_q && (state_q == SPLIT_IDLE) && !q_full_i;

  // ----------------------------------------------------------------------
  // Downstream request and upstream acceptance
  // ----------------------------------------------------------------------
  always_comb begin
    if (state_q == SPLIT_BUSY) begin
      m_ar_addr_o  = addr_q;
      m_ar_id_o    = id_q;
      m_ar_size_o  = size_q;
      m_ar_burst_o = burst_q;
      m_ar_valid_o = 1'b1;
      s_ar_ready_o = 1'b0;
    end else begin
      m_ar_addr_o  = s_ar_addr_i;
      m_ar_id_o    = s_ar_id_i;
      m_ar_size_o  = s_ar_size_i;
      m_ar_burst_o = s_ar_burst_i;
      m_ar_valid_o = s_ar_valid_i && can_take;
      // A single beat goes straight through, so it waits for downstream
      s_ar_ready_o = can_take && ((s_ar_len_i != '0) || m_ar_ready_i);
    end
  end

  assign m_ar_len_o   = '0;
  assign q_push_o     = s_ar_valid_i && s_ar_ready_o;
  assign q_push_len_o = s_ar_len_i;

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= SPLIT_IDLE;
      rdy_en_q <= 1'b0;
    end else begin
      rdy_en_q <= 1'b1;
      case (state_q)
        SPLIT_IDLE: begin
          if (q_push_o && (s_ar_len_i != '0)) begin
            state_q <= SPLIT_BUSY;
          end
        end
        SPLIT_BUSY: begin
          if (m_ar_ready_i && (rem_q == '0)) begin
            state_q <= SPLIT_IDLE;
          end
        end
        default: state_q <= SPLIT_IDLE;
      endcase
    end
  end

  // Burst payload
  always_ff @(posedge clk_i) begin
    if (state_q == SPLIT_IDLE) begin
      if (q_push_o) begin
        id_q    <= s_ar_id_i;
        size_q  <= s_ar_size_i;
        burst_q <= s_ar_burst_i;
        if (m_ar_ready_i) begin
          addr_q <= next_addr(s_ar_addr_i, s_ar_size_i, s_ar_burst_i);
          rem_q  <= s_ar_len_i - len_t'(1);
        end else begin
          addr_q <= s_ar_addr_i;
          rem_q  <= s_ar_len_i;
        end
      end
    end else if (m_ar_ready_i) begin
      addr_q <= next_addr(addr_q, size_q, burst_q);
      rem_q  <= rem_q - len_t'(1);
    end
  end

endmodule

`default_nettype wire

/* common/splitter_cfg_pkg.sv */
// Burst splitter configuration: queue depth, counter widths and FSM states
`default_nettype none

package splitter_cfg_pkg;

  // Bursts that may be waiting for read data at once
  localparam int MAX_RD_TXNS = 4;

  // One bit above AxLEN so a full 256-beat count never wraps
  localparam int BEAT_CNT_W = axi_rd_pkg::LEN_W + 1;

  typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_BUSY
  } split_state_e;

  typedef enum logic {
    R_PASS,
    R_HOLD
  } rlast_state_e;

endpackage

`default_nettype wire

/* common/axi_rd_pkg.sv */
// AXI4 read channel field types, burst encodings and response codes
`default_nettype none

package axi_rd_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int ID_W   = 4;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 8;
  localparam int SIZE_W = 3;
  localparam int RESP_W = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [DATA_W-1:0] data_t;
  // Number of beats minus one, as carried on AxLEN
  typedef logic [LEN_W-1:0]  len_t;
  // Log2 of the bytes moved per beat
  typedef logic [SIZE_W-1:0] size_t;
  typedef logic [RESP_W-1:0] resp_t;

  // ----------------------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_EXOKAY = 2'b01;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire
